/* hdl/dcache_pkg.sv */
//////////////////////////////////////////////////
// Data cache shared definitions
// Direct-mapped geometry, address views and the
// request, response and memory command types
//////////////////////////////////////////////////

package dcache_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // Cache geometry, 64 lines of four words
    localparam int LINE_WORDS = 4;
    localparam int WORD_IDX_W = $clog2(LINE_WORDS);
    localparam int NUM_SETS   = 64;
    localparam int SET_W      = $clog2(NUM_SETS);
    localparam int TAG_W      = ADDR_W - SET_W - WORD_IDX_W - 2;

    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [SET_W-1:0]      set;
        logic [WORD_IDX_W-1:0] word;
        logic [1:0]            offset;
    } addr_fields_t;

    // Raw byte address for the bus, fields for the arrays
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      f;
    } addr_u;

    typedef struct packed {
        addr_u             addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
        logic              we;
        logic              uncacheable;
    } core_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } core_rsp_t;

    typedef enum logic [1:0] {
        LINE_READ,
        WORD_READ,
        WORD_WRITE
    } mem_kind_e;

    typedef struct packed {
        mem_kind_e         kind;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } mem_cmd_t;

    typedef struct packed {
        logic [WORD_IDX_W-1:0] word;
        logic [DATA_W-1:0]     data;
    } mem_beat_t;

endpackage

/* hdl/core_wb_slave.sv */
//////////////////////////////////////////////////
// Core-side Wishbone classic slave port
// Takes one request per cycle, forces it
// uncacheable when the cache is off, returns ack
//////////////////////////////////////////////////

`timescale 1ns/10ps

module core_wb_slave (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    input  logic                          wb_s_cyc_i,
    input  logic                          wb_s_stb_i,
    input  logic                          wb_s_we_i,
    input  logic [dcache_pkg::ADDR_W-1:0] wb_s_adr_i,
    input  logic [dcache_pkg::DATA_W-1:0] wb_s_dat_i,
    input  logic [dcache_pkg::BE_W-1:0]   wb_s_sel_i,
    output logic                          wb_s_ack_o,
    output logic [dcache_pkg::DATA_W-1:0] wb_s_dat_o,

    input  logic                          cfg_enable_i,

    output logic                          req_valid_o,
    output dcache_pkg::core_req_t         req_o,
    input  logic                          rsp_valid_i,
    input  dcache_pkg::core_rsp_t         rsp_i
);
    import dcache_pkg::*;

    logic              busy_q;
    logic              req_valid_q;
    logic              ack_q;
    core_req_t         req_q;
    logic [DATA_W-1:0] rdata_q;
    logic              accept;

    // New cycle seen while nothing is pending
    assign accept = wb_s_cyc_i && wb_s_stb_i && !busy_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q      <= 1'b0;
            req_valid_q <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            req_valid_q <= accept;
            ack_q       <= rsp_valid_i;
            // Stay busy through the ack cycle so the held stb is not taken twice
            if (accept) begin
                busy_q <= 1'b1;
            end else if (ack_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q.addr.raw    <= wb_s_adr_i;
            req_q.wdata       <= wb_s_dat_i;
            req_q.be          <= wb_s_sel_i;
            req_q.we          <= wb_s_we_i;
            req_q.uncacheable <= !cfg_enable_i;
        end
        if (rsp_valid_i) begin
            rdata_q <= rsp_i.rdata;
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;
    assign wb_s_ack_o  = ack_q;
    assign wb_s_dat_o  = rdata_q;

endmodule

/* hdl/dcache_lookup.sv */
//////////////////////////////////////////////////
// Data cache lookup and miss control
// Tag directory, data array, hit test, refill
// and write-through sequencing
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_lookup (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  req_valid_i,
    input  dcache_pkg::core_req_t req_i,
    output logic                  rsp_valid_o,
    output dcache_pkg::core_rsp_t rsp_o,

    output logic                  cmd_valid_o,
    output dcache_pkg::mem_cmd_t  cmd_o,
    input  logic                  beat_valid_i,
    input  dcache_pkg::mem_beat_t beat_i,
    input  logic                  cmd_done_i,

    output logic                  evt_read_miss_o
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CHECK,
        S_WAIT
    } state_e;

    state_e                state_q;
    core_req_t             req_q;
    logic                  rsp_valid_q;
    core_rsp_t             rsp_q;
    logic                  cmd_valid_q;
    mem_cmd_t              cmd_q;
    logic                  evt_q;

    // Directory and data storage
    logic [NUM_SETS-1:0]   valid_q;
    logic [TAG_W-1:0]      tag_q [NUM_SETS];
    logic [DATA_W-1:0]     data_q [NUM_SETS][LINE_WORDS];

    // Registered array read
    logic [DATA_W-1:0]     rd_data_q;
    logic [TAG_W-1:0]      rd_tag_q;
    logic                  rd_valid_q;

    logic                  hit;
    logic [DATA_W-1:0]     merged;
    logic                  data_we;
    logic [WORD_IDX_W-1:0] data_wword;
    logic [DATA_W-1:0]     data_wdata;
    logic                  dir_fill;

    // Uncacheable requests never hit
    assign hit = rd_valid_q && (rd_tag_q == req_q.addr.f.tag) && !req_q.uncacheable;

    // Byte merge of a write-through into the present line
    always_comb begin
        for (int b = 0; b < BE_W; b++) begin
            merged[8*b +: 8] = req_q.be[b] ? req_q.wdata[8*b +: 8] : rd_data_q[8*b +: 8];
        end
    end

    // Single write port, shared by write hits and refill beats
    always_comb begin
        data_we    = 1'b0;
        data_wword = req_q.addr.f.word;
        data_wdata = merged;
        if (state_q == S_CHECK && req_q.we && hit) begin
            data_we = 1'b1;
        end else if (state_q == S_WAIT && beat_valid_i && cmd_q.kind == LINE_READ) begin
            data_we    = 1'b1;
            data_wword = beat_i.word;
            data_wdata = beat_i.data;
        end
    end

    // Tag and valid are set once the whole line is in
    assign dir_fill = (state_q == S_WAIT) && cmd_done_i && (cmd_q.kind == LINE_READ);

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            rd_data_q  <= data_q[req_i.addr.f.set][req_i.addr.f.word];
            rd_tag_q   <= tag_q[req_i.addr.f.set];
            rd_valid_q <= valid_q[req_i.addr.f.set];
        end
        if (data_we) begin
            data_q[req_q.addr.f.set][data_wword] <= data_wdata;
        end
        if (dir_fill) begin
            tag_q[req_q.addr.f.set] <= req_q.addr.f.tag;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= S_IDLE;
            valid_q     <= '0;
            rsp_valid_q <= 1'b0;
            cmd_valid_q <= 1'b0;
            evt_q       <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            cmd_valid_q <= 1'b0;
            evt_q       <= 1'b0;
            if (dir_fill) begin
                valid_q[req_q.addr.f.set] <= 1'b1;
            end
            case (state_q)
                S_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (!req_q.we && hit) begin
                        rsp_valid_q <= 1'b1;
                        state_q     <= S_IDLE;
                    end else begin
                        // Miss, bypass or write goes out to memory
                        cmd_valid_q <= 1'b1;
                        evt_q       <= !req_q.we && !req_q.uncacheable;
                        state_q     <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (cmd_done_i) begin
                        rsp_valid_q <= 1'b1;
                        state_q     <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            req_q <= req_i;
        end
        if (state_q == S_CHECK) begin
            rsp_q.rdata <= rd_data_q;
            cmd_q.addr  <= req_q.addr.raw;
            cmd_q.wdata <= req_q.wdata;
            cmd_q.be    <= req_q.be;
            if (req_q.we) begin
                cmd_q.kind <= WORD_WRITE;
            end else if (req_q.uncacheable) begin
                cmd_q.kind <= WORD_READ;
            end else begin
                cmd_q.kind <= LINE_READ;
            end
        end
        // Requested word, from a refill beat or a single read
        if (state_q == S_WAIT && beat_valid_i && beat_i.word == req_q.addr.f.word) begin
            rsp_q.rdata <= beat_i.data;
        end
    end

    assign rsp_valid_o     = rsp_valid_q;
    assign rsp_o           = rsp_q;
    assign cmd_valid_o     = cmd_valid_q;
    assign cmd_o           = cmd_q;
    assign evt_read_miss_o = evt_q;

endmodule

/* hdl/mem_wb_master.sv */
//////////////////////////////////////////////////
// Memory-side Wishbone classic master port
// Runs four-beat line refills and single-word
// reads and writes
//////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_wb_master (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    input  logic                          cmd_valid_i,
    input  dcache_pkg::mem_cmd_t          cmd_i,
    output logic                          beat_valid_o,
    output dcache_pkg::mem_beat_t         beat_o,
    output logic                          cmd_done_o,

    output logic                          wb_m_cyc_o,
    output logic                          wb_m_stb_o,
    output logic                          wb_m_we_o,
    output logic [dcache_pkg::ADDR_W-1:0] wb_m_adr_o,
    output logic [dcache_pkg::DATA_W-1:0] wb_m_dat_o,
    output logic [dcache_pkg::BE_W-1:0]   wb_m_sel_o,
    input  logic                          wb_m_ack_i,
    input  logic [dcache_pkg::DATA_W-1:0] wb_m_dat_i
);
    import dcache_pkg::*;

    logic                  active_q;
    logic                  we_q;
    logic                  is_line_q;
    logic [WORD_IDX_W-1:0] cnt_q;
    logic                  done_q;
    logic                  beat_valid_q;
    mem_beat_t             beat_q;
    addr_u                 adr_q;
    logic [DATA_W-1:0]     dat_q;
    logic [BE_W-1:0]       sel_q;
    logic                  xfer;
    logic                  last;

    assign xfer = active_q && wb_m_ack_i;
    // Single transfers end on their first ack
    assign last = !is_line_q || (cnt_q == WORD_IDX_W'(LINE_WORDS - 1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q     <= 1'b0;
            we_q         <= 1'b0;
            is_line_q    <= 1'b0;
            cnt_q        <= '0;
            done_q       <= 1'b0;
            beat_valid_q <= 1'b0;
        end else begin
            done_q       <= 1'b0;
            beat_valid_q <= xfer && !we_q;
            if (cmd_valid_i && !active_q) begin
                active_q  <= 1'b1;
                we_q      <= (cmd_i.kind == WORD_WRITE);
                is_line_q <= (cmd_i.kind == LINE_READ);
                cnt_q     <= '0;
            end else if (xfer) begin
                if (last) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i && !active_q) begin
            adr_q.raw <= cmd_i.addr;
            dat_q     <= cmd_i.wdata;
            if (cmd_i.kind == LINE_READ) begin
                // Refill walks the line from word zero
                adr_q.f.word   <= '0;
                adr_q.f.offset <= '0;
                sel_q          <= '1;
            end else begin
                sel_q <= cmd_i.be;
            end
        end else if (xfer && !last) begin
            adr_q.f.word <= cnt_q + 1'b1;
        end
        if (xfer) begin
            beat_q.word <= adr_q.f.word;
            beat_q.data <= wb_m_dat_i;
        end
    end

    assign wb_m_cyc_o   = active_q;
    assign wb_m_stb_o   = active_q;
    assign wb_m_we_o    = we_q;
    assign wb_m_adr_o   = adr_q.raw;
    assign wb_m_dat_o   = dat_q;
    assign wb_m_sel_o   = sel_q;
    assign beat_valid_o = beat_valid_q;
    assign beat_o       = beat_q;
    assign cmd_done_o   = done_q;

endmodule

/* hdl/dcache_top.sv */
//////////////////////////////////////////////////
// Data cache top level
// Core port, lookup stage and memory port
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    // Core side
    input  logic                          wb_s_cyc_i,
    input  logic                          wb_s_stb_i,
    input  logic                          wb_s_we_i,
    input  logic [dcache_pkg::ADDR_W-1:0] wb_s_adr_i,
    input  logic [dcache_pkg::DATA_W-1:0] wb_s_dat_i,
    input  logic [dcache_pkg::BE_W-1:0]   wb_s_sel_i,
    output logic                          wb_s_ack_o,
    output logic [dcache_pkg::DATA_W-1:0] wb_s_dat_o,

    // Memory side
    output logic                          wb_m_cyc_o,
    output logic                          wb_m_stb_o,
    output logic                          wb_m_we_o,
    output logic [dcache_pkg::ADDR_W-1:0] wb_m_adr_o,
    output logic [dcache_pkg::DATA_W-1:0] wb_m_dat_o,
    output logic [dcache_pkg::BE_W-1:0]   wb_m_sel_o,
    input  logic                          wb_m_ack_i,
    input  logic [dcache_pkg::DATA_W-1:0] wb_m_dat_i,

    input  logic                          cfg_enable_i,
    output logic                          evt_read_miss_o
);
    import dcache_pkg::*;

    logic      req_valid;
    core_req_t req;
    logic      rsp_valid;
    core_rsp_t rsp;
    logic      cmd_valid;
    mem_cmd_t  cmd;
    logic      beat_valid;
    mem_beat_t beat;
    logic      cmd_done;

    core_wb_slave u_core_port (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .wb_s_cyc_i   (wb_s_cyc_i),
        .wb_s_stb_i   (wb_s_stb_i),
        .wb_s_we_i    (wb_s_we_i),
        .wb_s_adr_i   (wb_s_adr_i),
        .wb_s_dat_i   (wb_s_dat_i),
        .wb_s_sel_i   (wb_s_sel_i),
        .wb_s_ack_o   (wb_s_ack_o),
        .wb_s_dat_o   (wb_s_dat_o),
        .cfg_enable_i (cfg_enable_i),
        .req_valid_o  (req_valid),
        .req_o        (req),
        .rsp_valid_i  (rsp_valid),
        .rsp_i        (rsp)
    );

    dcache_lookup u_lookup (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .rsp_valid_o     (rsp_valid),
        .rsp_o           (rsp),
        .cmd_valid_o     (cmd_valid),
        .cmd_o           (cmd),
        .beat_valid_i    (beat_valid),
        .beat_i          (beat),
        .cmd_done_i      (cmd_done),
        .evt_read_miss_o (evt_read_miss_o)
    );

    mem_wb_master u_mem_port (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .beat_valid_o (beat_valid),
        .beat_o       (beat),
        .cmd_done_o   (cmd_done),
        .wb_m_cyc_o   (wb_m_cyc_o),
        .wb_m_stb_o   (wb_m_stb_o),
        .wb_m_we_o    (wb_m_we_o),
        .wb_m_adr_o   (wb_m_adr_o),
        .wb_m_dat_o   (wb_m_dat_o),
        .wb_m_sel_o   (wb_m_sel_o),
        .wb_m_ack_i   (wb_m_ack_i),
        .wb_m_dat_i   (wb_m_dat_i)
    );

endmodule

/* tb/dcache_checker.sv */
//////////////////////////////////////////////////
// Wishbone handshake assertions for the data cache
// Bound to the core and memory ports of the top
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_checker (
    input logic clk_i,
    input logic rst_ni,
    input logic wb_s_cyc_i,
    input logic wb_s_stb_i,
    input logic wb_s_ack_o,
    input logic wb_m_cyc_o,
    input logic wb_m_stb_o,
    input logic wb_m_ack_i
);

    // Core port
    s_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_s_ack_o |=> !wb_s_ack_o)
        else $error("core ack held longer than one cycle");
    s_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_s_ack_o |-> (wb_s_cyc_i && wb_s_stb_i))
        else $error("core ack outside an active cycle");
    s_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_s_stb_i && !wb_s_ack_o) |=> wb_s_stb_i)
        else $error("core stb dropped before ack");

    // Memory port
    m_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_m_ack_i |=> !wb_m_ack_i)
        else $error("memory ack held longer than one cycle");
    m_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_m_ack_i |-> (wb_m_cyc_o && wb_m_stb_o))
        else $error("memory ack outside an active cycle");
    m_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_m_stb_o && !wb_m_ack_i) |=> wb_m_stb_o)
        else $error("memory stb dropped before ack");

    // Both ports quiet in reset
    rst_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> (!wb_s_ack_o && !wb_m_ack_i && !wb_m_cyc_o))
        else $error("ack or memory cyc active during reset");

endmodule

bind dcache_top dcache_checker u_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_s_cyc_i (wb_s_cyc_i),
    .wb_s_stb_i (wb_s_stb_i),
    .wb_s_ack_o (wb_s_ack_o),
    .wb_m_cyc_o (wb_m_cyc_o),
    .wb_m_stb_o (wb_m_stb_o),
    .wb_m_ack_i (wb_m_ack_i)
);

/* tb/dcache_tb.sv */
//////////////////////////////////////////////////
// Data cache testbench
// Core-side stimulus, memory model with random
// ack delay, reference model and response checks
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_tb;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 200;
    localparam int RAND_OPS  = 300;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        is_read;
        logic        miss;
        logic [2:0]  xfers;
    } expect_t;

    logic        clk_i;
    logic        rst_ni;
    logic        wb_s_cyc_i;
    logic        wb_s_stb_i;
    logic        wb_s_we_i;
    logic [31:0] wb_s_adr_i;
    logic [31:0] wb_s_dat_i;
    logic [3:0]  wb_s_sel_i;
    logic        wb_s_ack_o;
    logic [31:0] wb_s_dat_o;
    logic        wb_m_cyc_o;
    logic        wb_m_stb_o;
    logic        wb_m_we_o;
    logic [31:0] wb_m_adr_o;
    logic [31:0] wb_m_dat_o;
    logic [3:0]  wb_m_sel_o;
    logic        wb_m_ack_i;
    logic [31:0] wb_m_dat_i;
    logic        cfg_enable_i;
    logic        evt_read_miss_o;

    // Memory model state
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] mem_rng;
    logic        mem_armed;
    logic [1:0]  mem_cnt;

    // Reference model state
    logic [31:0] ref_mem   [MEM_WORDS];
    logic        ref_valid [64];
    logic [21:0] ref_tag   [64];
    logic [31:0] ref_line  [64][4];

    expect_t     exp_q [$];
    expect_t     cur;
    int          seen_miss;
    int          seen_xfer;
    int          err_data  = 0;
    int          err_miss  = 0;
    int          err_xfer  = 0;
    int          err_proto = 0;
    logic        stalled   = 1'b0;

    dcache_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Initial memory contents distinct for every word address
    function automatic logic [31:0] fill_word(input logic [31:0] idx);
        return (idx * 32'h9E37_79B9) ^ 32'h0BAD_F00D;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Direct-mapped write-through model with no write-allocate
    function automatic logic [31:0] ref_access(input logic we, input logic [31:0] addr,
                                               input logic [31:0] wdata, input logic [3:0] be,
                                               input logic en, output logic miss,
                                               output int xfers);
        logic [9:0]  idx;
        logic [5:0]  set;
        logic [1:0]  word;
        logic [21:0] tag;
        logic        present;
        logic [31:0] res;
        idx     = addr[11:2];
        set     = addr[9:4];
        word    = addr[3:2];
        tag     = addr[31:10];
        present = en && ref_valid[set] && (ref_tag[set] == tag);
        miss    = 1'b0;
        xfers   = 1;
        res     = 32'h0;
        if (we) begin
            ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
            if (present) begin
                ref_line[set][word] = merge_bytes(ref_line[set][word], wdata, be);
            end
        end else if (!en) begin
            res = ref_mem[idx];
        end else begin
            if (present) begin
                xfers = 0;
            end else begin
                // Refill takes the whole line as memory holds it now
                miss           = 1'b1;
                xfers          = 4;
                ref_valid[set] = 1'b1;
                ref_tag[set]   = tag;
                for (int w = 0; w < 4; w++) begin
                    ref_line[set][2'(w)] = ref_mem[{idx[9:2], 2'(w)}];
                end
            end
            res = ref_line[set][word];
        end
        return res;
    endfunction

    // Memory slave acking after one to three cycles
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_m_ack_i <= 1'b0;
            wb_m_dat_i <= '0;
            mem_armed  <= 1'b0;
            mem_cnt    <= '0;
            mem_rng    <= 32'h5af;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[10'(i)] <= fill_word(32'(i));
            end
        end else begin
            wb_m_ack_i <= 1'b0;
            if (wb_m_cyc_o && wb_m_stb_o && !wb_m_ack_i) begin
                if (!mem_armed) begin
                    mem_armed <= 1'b1;
                    mem_cnt   <= 2'(mem_rng % 3);
                    mem_rng   <= xorshift32(mem_rng);
                end else if (mem_cnt != 2'd0) begin
                    mem_cnt <= mem_cnt - 2'd1;
                end else begin
                    mem_armed  <= 1'b0;
                    wb_m_ack_i <= 1'b1;
                    wb_m_dat_i <= mem[wb_m_adr_o[11:2]];
                    if (wb_m_we_o) begin
                        mem[wb_m_adr_o[11:2]] <= merge_bytes(mem[wb_m_adr_o[11:2]],
                                                             wb_m_dat_o, wb_m_sel_o);
                    end
                end
            end
        end
    end

    // Compare each core ack against the oldest expected entry
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            seen_miss = 0;
            seen_xfer = 0;
        end else begin
            if (evt_read_miss_o) begin
                seen_miss = seen_miss + 1;
            end
            if (wb_m_ack_i) begin
                seen_xfer = seen_xfer + 1;
            end
            if (wb_s_ack_o) begin
                assert (exp_q.size() > 0) else begin
                    $display("Core ack arrived with no request outstanding at %0t", $time);
                    err_proto = err_proto + 1;
                end
                if (exp_q.size() > 0) begin
                    cur = exp_q.pop_front();
                    if (cur.is_read) begin
                        assert (wb_s_dat_o == cur.data) else begin
                            $display("ERR %0t read %h returned %h, expected %h",
                                     $time, cur.addr, wb_s_dat_o, cur.data);
                            err_data = err_data + 1;
                        end
                    end
                    assert (seen_miss == int'(cur.miss)) else begin
                        $display("ERR %0t access %h gave %0d miss pulses, expected %0d",
                                 $time, cur.addr, seen_miss, cur.miss);
                        err_miss = err_miss + 1;
                    end
                    assert (seen_xfer == int'(cur.xfers)) else begin
                        $display("ERR %0t access %h used %0d memory transfers, expected %0d",
                                 $time, cur.addr, seen_xfer, cur.xfers);
                        err_xfer = err_xfer + 1;
                    end
                end
                seen_miss = 0;
                seen_xfer = 0;
            end
        end
    end

    task automatic set_enable(input logic en);
        @(posedge clk_i);
        cfg_enable_i <= en;
    endtask

    // One classic Wishbone cycle on the core port
    task automatic core_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be);
        expect_t entry;
        logic    miss;
        int      xfers;
        logic    got_ack;
        if (!stalled) begin
            @(posedge clk_i);
            entry.addr    = addr;
            entry.data    = ref_access(we, addr, wdata, be, cfg_enable_i, miss, xfers);
            entry.is_read = !we;
            entry.miss    = miss;
            entry.xfers   = 3'(xfers);
            exp_q.push_back(entry);
            wb_s_cyc_i <= 1'b1;
            wb_s_stb_i <= 1'b1;
            wb_s_we_i  <= we;
            wb_s_adr_i <= addr;
            wb_s_dat_i <= wdata;
            wb_s_sel_i <= be;
            got_ack = 1'b0;
            for (int n = 0; n < TIMEOUT && !got_ack; n++) begin
                @(posedge clk_i);
                got_ack = wb_s_ack_o;
            end
            if (!got_ack) begin
                $display("Timeout: no core ack for address %h at %0t", addr, $time);
                stalled = 1'b1;
            end else begin
                wb_s_cyc_i <= 1'b0;
                wb_s_stb_i <= 1'b0;
            end
        end
    endtask

    initial begin
        logic [31:0] stim_rng;
        logic [31:0] r_addr;
        logic [3:0]  r_be;
        logic        r_we;
        int          total;
        rst_ni       <= 1'b0;
        wb_s_cyc_i   <= 1'b0;
        wb_s_stb_i   <= 1'b0;
        wb_s_we_i    <= 1'b0;
        wb_s_adr_i   <= '0;
        wb_s_dat_i   <= '0;
        wb_s_sel_i   <= '0;
        cfg_enable_i <= 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[10'(i)] = fill_word(32'(i));
        end
        for (int s = 0; s < 64; s++) begin
            ref_valid[6'(s)] = 1'b0;
            ref_tag[6'(s)]   = '0;
            for (int w = 0; w < 4; w++) begin
                ref_line[6'(s)][2'(w)] = '0;
            end
        end
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;

        // Cold miss followed by hits on the rest of the line
        core_access(1'b0, 32'h0000_0044, '0, 4'hF);
        core_access(1'b0, 32'h0000_0040, '0, 4'hF);
        core_access(1'b0, 32'h0000_0048, '0, 4'hF);
        core_access(1'b0, 32'h0000_004C, '0, 4'hF);
        // Partial write-through into a present line
        core_access(1'b1, 32'h0000_0048, 32'hDEAD_BEEF, 4'b0101);
        core_access(1'b0, 32'h0000_0048, '0, 4'hF);
        // Conflict in set 4 evicts the line and the old address misses again
        core_access(1'b0, 32'h0000_0448, '0, 4'hF);
        core_access(1'b0, 32'h0000_0044, '0, 4'hF);
        // Bypass reads with the cache off, one of them on the written word
        set_enable(1'b0);
        core_access(1'b0, 32'h0000_0084, '0, 4'hF);
        core_access(1'b0, 32'h0000_0048, '0, 4'hF);
        core_access(1'b0, 32'h0000_0044, '0, 4'hF);
        set_enable(1'b1);
        core_access(1'b0, 32'h0000_0084, '0, 4'hF);

        // Random traffic over two tags of a 2 KB window
        stim_rng = 32'h5af;
        for (int i = 0; i < RAND_OPS; i++) begin
            stim_rng = xorshift32(stim_rng);
            r_addr   = {21'h0, stim_rng[10:2], 2'b00};
            r_we     = (stim_rng[31:30] == 2'b00);
            r_be     = (stim_rng[27:24] == 4'h0) ? 4'hF : stim_rng[27:24];
            stim_rng = xorshift32(stim_rng);
            core_access(r_we, r_addr, stim_rng, r_we ? r_be : 4'hF);
        end

        for (int n = 0; n < TIMEOUT && exp_q.size() > 0; n++) begin
            @(posedge clk_i);
        end
        if (stalled || exp_q.size() > 0) begin
            $display("Timeout: core requests were left without a response");
        end
        total = err_data + err_miss + err_xfer + err_proto;
        $display("Errors: data %0d, miss %0d, transfers %0d, protocol %0d",
                 err_data, err_miss, err_xfer, err_proto);
        if (!stalled && exp_q.size() == 0 && total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/dcache_pkg.sv
hdl/core_wb_slave.sv
hdl/dcache_lookup.sv
hdl/mem_wb_master.sv
hdl/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_STR  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
